//--- Bender.yml
package:
  name: pinmux_reg

sources:
  - files:
      - rtl/pinmux_pkg.sv
      - rtl/reg_bus_frontend.sv
      - rtl/gpio_in_sync.sv
      - rtl/pinmux_cfg_regs.sv
      - rtl/gpio_int_status.sv
      - rtl/pinmux_read_mux.sv
      - rtl/pinmux_reg_top.sv
  - target: test
    files:
      - bench/tb_pinmux_reg.sv

//--- bench/tb_pinmux_reg.sv
`timescale 1ns/1ps

module tb_pinmux_reg;

   import pinmux_pkg::*;

   localparam reg_word_addr_t ADDR_UNUSED = 5'd20;
   localparam gpio_vec_t      PINS        = 32'h5A5A_C3C3;   // Pad pattern for capture

   // One bus access with its side inputs and expected read data
   typedef struct packed {
      logic           wr;
      logic           rnd;       // Random wdata, or expect from shadow on a read
      reg_word_addr_t addr;
      reg_data_t      wdata;
      reg_be_t        be;
      gpio_vec_t      pins;
      gpio_vec_t      events;    // Pulsed in the access cycle
      logic [3:0]     ints;      // ext[1:0], usb, i2cm
      reg_data_t      exp;
   } entry_t;

   logic        mclk, h_reset_n;
   logic        reg_cs, reg_wr, reg_ack;
   logic [7:0]  reg_addr;
   reg_data_t   reg_wdata, reg_rdata, fuse_mhartid;
   reg_be_t     reg_be;
   logic [1:0]  ext_intr_in;
   logic        usb_intr, i2cm_intr, soft_irq;
   gpio_vec_t   gpio_in_data, gpio_int_event, cfg_gpio_data_in, gpio_prev_indata;
   irq_vec_t    irq_lines;
   user_irq_t   user_irq;
   gpio_cfg_t   gpio_cfg;

   entry_t      stim[$];
   reg_data_t   shadow [0:31];   // Expected register contents
   gpio_vec_t   st_model;        // Expected interrupt status
   integer      seed;
   int          cycles = 0;
   int          cycle_limit = 100;
   int          fail_count = 0;

   pinmux_reg_top i_dut (
      .mclk(mclk), .h_reset_n(h_reset_n), .reg_cs(reg_cs), .reg_wr(reg_wr),
      .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_be(reg_be),
      .reg_rdata(reg_rdata), .reg_ack(reg_ack), .ext_intr_in(ext_intr_in),
      .usb_intr(usb_intr), .i2cm_intr(i2cm_intr), .gpio_in_data(gpio_in_data),
      .gpio_int_event(gpio_int_event), .fuse_mhartid(fuse_mhartid),
      .irq_lines(irq_lines), .soft_irq(soft_irq), .user_irq(user_irq),
      .gpio_cfg(gpio_cfg), .cfg_gpio_data_in(cfg_gpio_data_in),
      .gpio_prev_indata(gpio_prev_indata)
   );

   initial
   begin
      mclk = 1'b0;
      forever #4 mclk = ~mclk;   // 8 ns period
   end

   // Watchdog on total run length
   always @(posedge mclk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout: reg_ack never came back, run stopped after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Simulation timed out");
      end
   end

   // ------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------
   task automatic report_failure(input string msg);
      fail_count++;
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Check failed");
   endtask

   task automatic check_rdata(input string what, input reg_data_t got, input reg_data_t exp);
      if (got !== exp)
         report_failure($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_irq(input irq_vec_t got, input irq_vec_t exp);
      if (got !== exp)
         report_failure($sformatf("irq_lines got %h expected %h", got, exp));
   endtask

   task automatic check_gpio_cfg(input gpio_cfg_t got, input gpio_cfg_t exp);
      if (got !== exp)
         report_failure($sformatf("gpio_cfg got %h expected %h", got, exp));
   endtask

   task automatic check_pins(input string what, input gpio_vec_t got, input gpio_vec_t exp);
      if (got !== exp)
         report_failure($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_sw_irq(input logic soft_got, input logic soft_exp,
                               input user_irq_t user_got, input user_irq_t user_exp);
      if ((soft_got !== soft_exp) || (user_got !== user_exp))
         report_failure($sformatf("soft/user irq got %b/%h expected %b/%h",
                                  soft_got, user_got, soft_exp, user_exp));
   endtask

   // ------------------------------------------------------------------
   // Model and bus helpers
   // ------------------------------------------------------------------
   function automatic reg_data_t expand_be(input reg_be_t be);
      reg_data_t m;
      for (int i = 0; i < 4; i++)
         m[i*8 +: 8] = be[i] ? 8'hFF : 8'h00;   // One byte per enable
      return m;
   endfunction

   task automatic push_entry(input logic wr, input logic rnd, input reg_word_addr_t addr,
                             input reg_data_t wdata, input reg_be_t be, input gpio_vec_t pins,
                             input gpio_vec_t events, input logic [3:0] ints,
                             input reg_data_t exp);
      stim.push_back({wr, rnd, addr, wdata, be, pins, events, ints, exp});
   endtask

   task automatic bus_access(input entry_t e, output reg_data_t rdata);
      reg_cs         = 1'b1;
      reg_wr         = e.wr;
      reg_addr       = {1'b0, e.addr, 2'b00};     // Word index to byte address
      reg_wdata      = e.wdata;
      reg_be         = e.be;
      gpio_in_data   = e.pins;
      gpio_int_event = e.events;
      {ext_intr_in, usb_intr, i2cm_intr} = e.ints;
      @(posedge mclk);
      #1;
      while (reg_ack !== 1'b1)
      begin
         @(posedge mclk);
         #1;
      end
      rdata          = reg_rdata;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      gpio_int_event = '0;                         // Single-cycle event pulse
      @(posedge mclk);                             // Idle cycle between accesses
      #1;
   endtask

   task automatic update_model(input entry_t e);
      reg_data_t m;
      gpio_vec_t clr;
      gpio_vec_t set;
      m   = expand_be(e.be);
      clr = '0;
      set = '0;
      if (e.wr)
      begin
         case (e.addr)
            ADDR_FUSE_ID, ADDR_GPIO_OUT, ADDR_GPIO_DIR, ADDR_GPIO_TYPE,
            ADDR_INT_MASK, ADDR_POS_SEL, ADDR_NEG_SEL:
               shadow[e.addr] = (shadow[e.addr] & ~m) | (e.wdata & m);
            ADDR_IRQ_CTRL : shadow[e.addr] = ((shadow[e.addr] & ~m) | (e.wdata & m)) & 32'h7FFF;
            ADDR_INT_STAT : clr = e.wdata & m;
            ADDR_INT_SET  : set = e.wdata & m;
            default       : ;
         endcase
      end
      st_model = (st_model & ~clr) | set | e.events;   // Event wins over clear
   endtask

   task automatic check_outputs(input entry_t e);
      gpio_cfg_t cfg_exp;
      irq_vec_t  irq_exp;
      cfg_exp.out_data    = shadow[ADDR_GPIO_OUT];
      cfg_exp.dir_sel     = shadow[ADDR_GPIO_DIR];
      cfg_exp.out_type    = shadow[ADDR_GPIO_TYPE];
      cfg_exp.posedge_sel = shadow[ADDR_POS_SEL];
      cfg_exp.negedge_sel = shadow[ADDR_NEG_SEL];
      check_gpio_cfg(gpio_cfg, cfg_exp);
      irq_exp = {|(st_model & shadow[ADDR_INT_MASK]), e.ints,
                 shadow[ADDR_IRQ_CTRL][IRQ_CTRL_LINES-1:0]};
      check_irq(irq_lines, irq_exp);
      check_sw_irq(soft_irq, shadow[ADDR_IRQ_CTRL][SOFT_IRQ_BIT],
                   user_irq, shadow[ADDR_IRQ_CTRL][USER_IRQ_LSB +: 3]);
      check_rdata("fuse_mhartid", fuse_mhartid, shadow[ADDR_FUSE_ID]);
   endtask

   // ------------------------------------------------------------------
   // Stimulus table
   // ------------------------------------------------------------------
   task automatic build_table();
      // Reset values
      push_entry(0, 0, ADDR_CHIP_ID,   0, 0, 0, 0, 0, CHIP_ID_VALUE);
      push_entry(0, 0, ADDR_FUSE_ID,   0, 0, 0, 0, 0, FUSE_ID_RESET);
      push_entry(0, 0, ADDR_GPIO_OUT,  0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_GPIO_DIR,  0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_GPIO_TYPE, 0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_IRQ_CTRL,  0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_INT_STAT,  0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_INT_SET,   0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_INT_MASK,  0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_POS_SEL,   0, 0, 0, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_NEG_SEL,   0, 0, 0, 0, 0, 32'h0);
      // Byte-enabled writes
      push_entry(1, 0, ADDR_GPIO_OUT,  32'h1234_5678, 4'b1111, 0, 0, 0, 0);
      push_entry(1, 0, ADDR_GPIO_OUT,  32'hAABB_CCDD, 4'b0101, 0, 0, 0, 0);
      push_entry(0, 0, ADDR_GPIO_OUT,  0, 0, 0, 0, 0, 32'h12BB_56DD);
      push_entry(1, 0, ADDR_GPIO_DIR,  32'hFFFF_FFFF, 4'b1000, 0, 0, 0, 0);
      push_entry(0, 0, ADDR_GPIO_DIR,  0, 0, 0, 0, 0, 32'hFF00_0000);
      push_entry(1, 1, ADDR_GPIO_TYPE, 0, 4'b0110, 0, 0, 0, 0);
      push_entry(0, 1, ADDR_GPIO_TYPE, 0, 0, 0, 0, 0, 0);
      push_entry(1, 1, ADDR_POS_SEL,   0, 4'b1010, 0, 0, 0, 0);
      push_entry(0, 1, ADDR_POS_SEL,   0, 0, 0, 0, 0, 0);
      push_entry(1, 0, ADDR_NEG_SEL,   32'h0F0F_0F0F, 4'b0011, 0, 0, 0, 0);
      push_entry(1, 0, ADDR_NEG_SEL,   32'hFFFF_FFFF, 4'b0100, 0, 0, 0, 0);
      push_entry(0, 0, ADDR_NEG_SEL,   0, 0, 0, 0, 0, 32'h00FF_0F0F);
      push_entry(1, 0, ADDR_FUSE_ID,   32'h1111_2222, 4'b1100, 0, 0, 0, 0);
      push_entry(0, 0, ADDR_FUSE_ID,   0, 0, 0, 0, 0, 32'h1111_A55A);
      // Pin capture, unused address ignores writes
      push_entry(1, 0, ADDR_UNUSED,    32'hFFFF_FFFF, 4'b1111, PINS, 0, 0, 0);
      push_entry(0, 0, ADDR_UNUSED,    0, 0, PINS, 0, 0, 32'h0);
      push_entry(0, 0, ADDR_GPIO_IN,   0, 0, PINS, 0, 0, PINS);
      // Interrupt status, W1C and W1S
      push_entry(1, 0, ADDR_UNUSED,    0, 4'b0000, PINS, 32'h0000_00F1, 0, 0);
      push_entry(0, 0, ADDR_INT_STAT,  0, 0, PINS, 0, 0, 32'h0000_00F1);
      push_entry(0, 0, ADDR_INT_SET,   0, 0, PINS, 0, 0, 32'h0000_00F1);
      push_entry(1, 0, ADDR_INT_SET,   32'h0300_8000, 4'b1111, PINS, 0, 0, 0);
      push_entry(0, 0, ADDR_INT_STAT,  0, 0, PINS, 0, 0, 32'h0300_80F1);
      push_entry(1, 0, ADDR_INT_STAT,  32'hFFFF_FFFF, 4'b0001, PINS, 0, 0, 0);
      push_entry(0, 0, ADDR_INT_SET,   0, 0, PINS, 0, 0, 32'h0300_8000);
      // Bit 25 not written stays, bit 24 cleared and posted together stays
      push_entry(1, 0, ADDR_INT_STAT,  32'h0100_8000, 4'b1111, PINS, 32'h0100_0000, 0, 0);
      push_entry(0, 0, ADDR_INT_STAT,  0, 0, PINS, 0, 0, 32'h0300_0000);
      // Interrupt lines
      push_entry(1, 0, ADDR_INT_MASK,  32'h0100_0000, 4'b1000, PINS, 0, 0, 0);
      push_entry(0, 0, ADDR_INT_MASK,  0, 0, PINS, 0, 0, 32'h0100_0000);
      push_entry(1, 0, ADDR_IRQ_CTRL,  32'hFFFF_D9A5, 4'b0011, PINS, 0, 4'b1010, 0);
      push_entry(0, 0, ADDR_IRQ_CTRL,  0, 0, PINS, 0, 4'b0101, 32'h0000_59A5);
      push_entry(1, 0, ADDR_IRQ_CTRL,  32'hFFFF_FFFF, 4'b1100, PINS, 0, 4'b0011, 0);
      push_entry(0, 0, ADDR_IRQ_CTRL,  0, 0, PINS, 0, 4'b1100, 32'h0000_59A5);
      push_entry(1, 0, ADDR_INT_STAT,  32'hFFFF_FFFF, 4'b1111, PINS, 0, 0, 0);
      push_entry(0, 0, ADDR_INT_STAT,  0, 0, PINS, 0, 0, 32'h0);
   endtask

   // ------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------
   initial
   begin
      entry_t    e;
      reg_data_t rdata;
      reg_data_t exp_data;
      seed           = 32'h3faf;
      h_reset_n      = 1'b0;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      reg_addr       = '0;
      reg_wdata      = '0;
      reg_be         = '0;
      ext_intr_in    = '0;
      usb_intr       = 1'b0;
      i2cm_intr      = 1'b0;
      gpio_in_data   = '0;
      gpio_int_event = '0;
      for (int i = 0; i < 32; i++)
         shadow[i] = '0;
      shadow[ADDR_FUSE_ID] = FUSE_ID_RESET;        // Hart ID resets non-zero
      st_model = '0;
      build_table();
      cycle_limit = 4 * stim.size() * 4 + 100;
      repeat (8) @(posedge mclk);
      #1 h_reset_n = 1'b1;
      @(posedge mclk);
      #1;
      foreach (stim[i])
      begin
         e = stim[i];
         if (e.rnd && e.wr)
            e.wdata = $random(seed);
         bus_access(e, rdata);
         update_model(e);
         if (!e.wr)
         begin
            exp_data = e.rnd ? shadow[e.addr] : e.exp;
            check_rdata($sformatf("read of address %0d", e.addr), rdata, exp_data);
            if (e.addr == ADDR_GPIO_IN)
            begin
               check_pins("cfg_gpio_data_in", cfg_gpio_data_in, e.pins);
               check_pins("gpio_prev_indata", gpio_prev_indata, e.pins);
            end
         end
         check_outputs(e);
      end
      if (fail_count == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- rtl/gpio_in_sync.sv
`timescale 1ns/1ps

module gpio_in_sync (
   input  logic                   mclk,
   input  logic                   h_reset_n,
   input  pinmux_pkg::gpio_vec_t  gpio_in_data,    // Async pad inputs
   output pinmux_pkg::gpio_vec_t  gpio_sync,       // After two flops
   output pinmux_pkg::gpio_vec_t  gpio_captured    // Third stage, register 2
);

   import pinmux_pkg::*;

   gpio_vec_t gpio_meta;   // First stage, may go metastable

   // ------------------------------------------------------------------
   // Double sync, then capture
   // ------------------------------------------------------------------
   // Captured value lags gpio_sync by one edge so edge logic downstream
   // can compare current against previous
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         gpio_meta     <= '0;
         gpio_sync     <= '0;
         gpio_captured <= '0;
      end
      else
      begin
         gpio_meta     <= gpio_in_data;
         gpio_sync     <= gpio_meta;
         gpio_captured <= gpio_sync;     // Read back at address 2
      end
   end

endmodule

//--- rtl/gpio_int_status.sv
`timescale 1ns/1ps

module gpio_int_status (
   input  logic                     mclk,
   input  logic                     h_reset_n,
   input  pinmux_pkg::reg_wr_req_t  wr_req,
   input  pinmux_pkg::gpio_vec_t    gpio_int_event,  // Edge events from GPIO block
   input  pinmux_pkg::gpio_vec_t    int_mask,
   output pinmux_pkg::gpio_vec_t    int_status,
   output logic                     gpio_intr        // To irq_lines bit 15
);

   import pinmux_pkg::*;

   reg_data_t wr_mask;
   gpio_vec_t sw_clr;      // Bits written one at address 9
   gpio_vec_t sw_set;      // Bits written one at address 10
   gpio_vec_t status_nxt;

   assign wr_mask = be_mask(wr_req.be);

   // ------------------------------------------------------------------
   // Software set and clear
   // ------------------------------------------------------------------
   always_comb
   begin
      sw_clr = '0;
      sw_set = '0;
      if (wr_req.strobe && (wr_req.addr == ADDR_INT_STAT))
      begin
         sw_clr = wr_req.wdata & wr_mask;    // Write one to clear
      end
      if (wr_req.strobe && (wr_req.addr == ADDR_INT_SET))
      begin
         sw_set = wr_req.wdata & wr_mask;    // Write one to set
      end

      // Events ORed last so posting beats a clear in the same cycle
      status_nxt = (int_status & ~sw_clr) | sw_set | gpio_int_event;
   end

   // Sticky status, updated every cycle
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         int_status <= '0;
      end
      else
      begin
         int_status <= status_nxt;
      end
   end

   assign gpio_intr = |(int_status & int_mask);

endmodule

//--- rtl/pinmux_cfg_regs.sv
`timescale 1ns/1ps

module pinmux_cfg_regs (
   input  logic                     mclk,
   input  logic                     h_reset_n,
   input  pinmux_pkg::reg_wr_req_t  wr_req,

   // Interrupt sources
   input  logic [1:0]               ext_intr_in,
   input  logic                     usb_intr,
   input  logic                     i2cm_intr,
   input  logic                     gpio_intr,      // Masked GPIO status

   // Register values
   output pinmux_pkg::reg_data_t    fuse_mhartid,
   output pinmux_pkg::reg_data_t    irq_ctrl,       // Readback of register 6
   output pinmux_pkg::gpio_cfg_t    gpio_cfg,
   output pinmux_pkg::gpio_vec_t    int_mask,

   // RISC interrupt lines
   output pinmux_pkg::irq_vec_t     irq_lines,
   output logic                     soft_irq,
   output pinmux_pkg::user_irq_t    user_irq
);

   import pinmux_pkg::*;

   reg_data_t                wr_mask;      // Byte enables per bit
   reg_data_t                irq_ctrl_wr;  // Register 6 after merge
   logic [IRQ_CTRL_BITS-1:0] irq_ctrl_q;   // Only implemented bits

   // Replace enabled bytes of a register with write data
   function automatic reg_data_t merge(reg_data_t old_val, reg_data_t wdata,
                                       reg_data_t mask);
      return (old_val & ~mask) | (wdata & mask);
   endfunction

   assign wr_mask = be_mask(wr_req.be);

   // Bytes 2 and 3 fall outside the implemented field and are dropped
   assign irq_ctrl_wr = merge(irq_ctrl, wr_req.wdata, wr_mask);

   // ------------------------------------------------------------------
   // Writable registers
   // ------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         fuse_mhartid <= FUSE_ID_RESET;  // Non-zero hart ID at reset
         gpio_cfg     <= '0;
         int_mask     <= '0;             // All GPIO interrupts masked
         irq_ctrl_q   <= '0;
      end
      else if (wr_req.strobe)
      begin
         case (wr_req.addr)
            ADDR_FUSE_ID   : fuse_mhartid <= merge(fuse_mhartid, wr_req.wdata, wr_mask);
            ADDR_GPIO_OUT  :
            begin
               gpio_cfg.out_data <= merge(gpio_cfg.out_data, wr_req.wdata, wr_mask);
            end
            ADDR_GPIO_DIR  :
            begin
               gpio_cfg.dir_sel <= merge(gpio_cfg.dir_sel, wr_req.wdata, wr_mask);
            end
            ADDR_GPIO_TYPE :
            begin
               gpio_cfg.out_type <= merge(gpio_cfg.out_type, wr_req.wdata, wr_mask);
            end
            ADDR_IRQ_CTRL  : irq_ctrl_q <= irq_ctrl_wr[IRQ_CTRL_BITS-1:0];
            ADDR_INT_MASK  : int_mask <= merge(int_mask, wr_req.wdata, wr_mask);
            ADDR_POS_SEL   :
            begin
               gpio_cfg.posedge_sel <= merge(gpio_cfg.posedge_sel, wr_req.wdata, wr_mask);
            end
            ADDR_NEG_SEL   :
            begin
               gpio_cfg.negedge_sel <= merge(gpio_cfg.negedge_sel, wr_req.wdata, wr_mask);
            end
            default        : ;            // Read-only, status or unused
         endcase
      end
   end

   // Upper bits of register 6 read as zero
   assign irq_ctrl = {{(REG_DATA_W - IRQ_CTRL_BITS){1'b0}}, irq_ctrl_q};

   // ------------------------------------------------------------------
   // Interrupt line composition
   // ------------------------------------------------------------------
   // MSB first: gpio, ext[1:0], usb, i2cm, then software lines
   assign irq_lines = {gpio_intr, ext_intr_in, usb_intr, i2cm_intr,
                       irq_ctrl_q[IRQ_CTRL_LINES-1:0]};
   assign soft_irq  = irq_ctrl_q[SOFT_IRQ_BIT];
   assign user_irq  = irq_ctrl_q[USER_IRQ_LSB +: USER_IRQ_W];

endmodule

//--- rtl/pinmux_pkg.sv
package pinmux_pkg;

   // ------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------
   localparam int REG_DATA_W    = 32;
   localparam int REG_BE_W      = REG_DATA_W / 8;
   localparam int REG_ADDR_W    = 8;                  // Byte address on the bus
   localparam int WORD_ADDR_LSB = 2;
   localparam int WORD_ADDR_W   = 5;                  // Byte address bits 6..2
   localparam int GPIO_W        = 32;
   localparam int IRQ_W         = 16;
   localparam int USER_IRQ_W    = 3;

   typedef logic [REG_DATA_W-1:0]  reg_data_t;
   typedef logic [REG_BE_W-1:0]    reg_be_t;
   typedef logic [WORD_ADDR_W-1:0] reg_word_addr_t;
   typedef logic [GPIO_W-1:0]      gpio_vec_t;        // One bit per pin
   typedef logic [IRQ_W-1:0]       irq_vec_t;
   typedef logic [USER_IRQ_W-1:0]  user_irq_t;

   // One-shot write request, 42 bits
   typedef struct packed {
      logic           strobe;
      reg_word_addr_t addr;
      reg_data_t      wdata;
      reg_be_t        be;
   } reg_wr_req_t;

   // GPIO config going out to the pad control block
   typedef struct packed {
      gpio_vec_t out_data;
      gpio_vec_t dir_sel;      // Pin direction at the pad
      gpio_vec_t out_type;     // 0 static, 1 waveform
      gpio_vec_t posedge_sel;
      gpio_vec_t negedge_sel;
   } gpio_cfg_t;

   // ------------------------------------------------------------------
   // Register map, word addresses
   // ------------------------------------------------------------------
   localparam reg_word_addr_t ADDR_CHIP_ID   = 5'd0;
   localparam reg_word_addr_t ADDR_FUSE_ID   = 5'd1;
   localparam reg_word_addr_t ADDR_GPIO_IN   = 5'd2;
   localparam reg_word_addr_t ADDR_GPIO_OUT  = 5'd3;
   localparam reg_word_addr_t ADDR_GPIO_DIR  = 5'd4;
   localparam reg_word_addr_t ADDR_GPIO_TYPE = 5'd5;
   localparam reg_word_addr_t ADDR_IRQ_CTRL  = 5'd6;
   localparam reg_word_addr_t ADDR_INT_STAT  = 5'd9;  // W1C
   localparam reg_word_addr_t ADDR_INT_SET   = 5'd10; // W1S, reads status
   localparam reg_word_addr_t ADDR_INT_MASK  = 5'd11;
   localparam reg_word_addr_t ADDR_POS_SEL   = 5'd12;
   localparam reg_word_addr_t ADDR_NEG_SEL   = 5'd13;

   // Chip identity
   localparam logic [15:0] MANU_ID  = 16'h8949;
   localparam logic [7:0]  CHIP_NUM = 8'h02;
   localparam logic [7:0]  CHIP_REV = 8'h01;
   localparam reg_data_t CHIP_ID_VALUE = {MANU_ID, CHIP_NUM, CHIP_REV};
   localparam reg_data_t FUSE_ID_RESET = 32'hA55A_A55A;

   // Interrupt control register layout
   localparam int IRQ_CTRL_BITS  = 15;
   localparam int SOFT_IRQ_BIT   = 11;
   localparam int USER_IRQ_LSB   = 12;
   localparam int IRQ_CTRL_LINES = 11;                // Low bits routed to irq_lines

   // Expand byte enables to a per-bit mask
   function automatic reg_data_t be_mask(reg_be_t be);
      reg_data_t mask;
      for (int i = 0; i < REG_BE_W; i++)
      begin
         mask[i*8 +: 8] = {8{be[i]}};
      end
      return mask;
   endfunction

endpackage

//--- rtl/pinmux_read_mux.sv
`timescale 1ns/1ps

module pinmux_read_mux (
   input  pinmux_pkg::reg_word_addr_t  rd_addr,
   input  pinmux_pkg::reg_data_t       fuse_mhartid,
   input  pinmux_pkg::reg_data_t       irq_ctrl,
   input  pinmux_pkg::gpio_vec_t       gpio_captured,
   input  pinmux_pkg::gpio_vec_t       int_status,
   input  pinmux_pkg::gpio_vec_t       int_mask,
   input  pinmux_pkg::gpio_cfg_t       gpio_cfg,
   output pinmux_pkg::reg_data_t       rd_data
);

   import pinmux_pkg::*;

   // ------------------------------------------------------------------
   // Read map
   // ------------------------------------------------------------------
   always_comb
   begin
      rd_data = '0;                                    // Unused addresses
      case (rd_addr)
         ADDR_CHIP_ID   : rd_data = CHIP_ID_VALUE;
         ADDR_FUSE_ID   : rd_data = fuse_mhartid;
         ADDR_GPIO_IN   : rd_data = gpio_captured;
         ADDR_GPIO_OUT  : rd_data = gpio_cfg.out_data;
         ADDR_GPIO_DIR  : rd_data = gpio_cfg.dir_sel;
         ADDR_GPIO_TYPE : rd_data = gpio_cfg.out_type;
         ADDR_IRQ_CTRL  : rd_data = irq_ctrl;
         // Set register has no storage of its own
         ADDR_INT_STAT,
         ADDR_INT_SET   : rd_data = int_status;
         ADDR_INT_MASK  : rd_data = int_mask;
         ADDR_POS_SEL   : rd_data = gpio_cfg.posedge_sel;
         ADDR_NEG_SEL   : rd_data = gpio_cfg.negedge_sel;
         default        : rd_data = '0;
      endcase
   end

endmodule

//--- rtl/pinmux_reg_top.sv
`timescale 1ns/1ps

module pinmux_reg_top (
   input  logic                   mclk,
   input  logic                   h_reset_n,

   // Register bus
   input  logic                   reg_cs,
   input  logic                   reg_wr,
   input  logic [7:0]             reg_addr,
   input  pinmux_pkg::reg_data_t  reg_wdata,
   input  pinmux_pkg::reg_be_t    reg_be,
   output pinmux_pkg::reg_data_t  reg_rdata,
   output logic                   reg_ack,

   // Interrupt sources
   input  logic [1:0]             ext_intr_in,
   input  logic                   usb_intr,
   input  logic                   i2cm_intr,
   input  pinmux_pkg::gpio_vec_t  gpio_in_data,
   input  pinmux_pkg::gpio_vec_t  gpio_int_event,

   // RISC config
   output pinmux_pkg::reg_data_t  fuse_mhartid,
   output pinmux_pkg::irq_vec_t   irq_lines,
   output logic                   soft_irq,
   output pinmux_pkg::user_irq_t  user_irq,

   // GPIO side
   output pinmux_pkg::gpio_cfg_t  gpio_cfg,
   output pinmux_pkg::gpio_vec_t  cfg_gpio_data_in,
   output pinmux_pkg::gpio_vec_t  gpio_prev_indata
);

   import pinmux_pkg::*;

   reg_wr_req_t    wr_req;
   reg_word_addr_t rd_addr;
   reg_data_t      rd_data;
   reg_data_t      irq_ctrl;
   gpio_vec_t      int_mask;
   gpio_vec_t      int_status;
   logic           gpio_intr;

   reg_bus_frontend u_frontend (
      .mclk, .h_reset_n, .reg_cs, .reg_wr, .reg_addr, .reg_wdata, .reg_be,
      .rd_data, .wr_req, .rd_addr, .reg_rdata, .reg_ack
   );

   gpio_in_sync u_gpio_sync (
      .mclk, .h_reset_n, .gpio_in_data,
      .gpio_sync     (gpio_prev_indata),
      .gpio_captured (cfg_gpio_data_in)
   );

   pinmux_cfg_regs u_cfg_regs (
      .mclk, .h_reset_n, .wr_req, .ext_intr_in, .usb_intr, .i2cm_intr, .gpio_intr,
      .fuse_mhartid, .irq_ctrl, .gpio_cfg, .int_mask, .irq_lines, .soft_irq, .user_irq
   );

   gpio_int_status u_int_status (
      .mclk, .h_reset_n, .wr_req, .gpio_int_event, .int_mask, .int_status, .gpio_intr
   );

   pinmux_read_mux u_read_mux (
      .rd_addr, .fuse_mhartid, .irq_ctrl,
      .gpio_captured (cfg_gpio_data_in),
      .int_status, .int_mask, .gpio_cfg, .rd_data
   );

endmodule

//--- rtl/reg_bus_frontend.sv
`timescale 1ns/1ps

module reg_bus_frontend (
   input  logic                        mclk,
   input  logic                        h_reset_n,

   // Register bus, slave side
   input  logic                        reg_cs,
   input  logic                        reg_wr,
   input  logic [7:0]                  reg_addr,
   input  pinmux_pkg::reg_data_t       reg_wdata,
   input  pinmux_pkg::reg_be_t         reg_be,
   output pinmux_pkg::reg_data_t       reg_rdata,
   output logic                        reg_ack,

   // Towards the register file
   input  pinmux_pkg::reg_data_t       rd_data,   // From read mux
   output pinmux_pkg::reg_wr_req_t     wr_req,
   output pinmux_pkg::reg_word_addr_t  rd_addr
);

   import pinmux_pkg::*;

   logic access;      // Access accepted on this edge

   // ------------------------------------------------------------------
   // Request decode
   // ------------------------------------------------------------------
   // Ack low marks the first cycle of an access, so the strobe is a
   // single pulse even while the master keeps reg_cs up
   assign access = reg_cs & ~reg_ack;

   assign rd_addr = reg_addr[WORD_ADDR_LSB +: WORD_ADDR_W];

   always_comb
   begin
      wr_req.strobe = access & reg_wr;
      wr_req.addr   = rd_addr;            // Same word index for both directions
      wr_req.wdata  = reg_wdata;
      wr_req.be     = reg_be;
   end

   // ------------------------------------------------------------------
   // Response
   // ------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         reg_ack <= 1'b0;
      end
      else
      begin
         reg_ack <= access;               // High one cycle per access
      end
   end

   // Read data captured with the ack
   always_ff @(posedge mclk)
   begin
      if (access)
      begin
         reg_rdata <= rd_data;
      end
   end

endmodule

//--- tb.f
rtl/pinmux_pkg.sv
rtl/reg_bus_frontend.sv
rtl/gpio_in_sync.sv
rtl/pinmux_cfg_regs.sv
rtl/gpio_int_status.sv
rtl/pinmux_read_mux.sv
rtl/pinmux_reg_top.sv
bench/tb_pinmux_reg.sv
